// ==== flist.f ====
hw/sync_pkg.sv
hw/sync_cfg_regs.sv
hw/radar_frame_timer.sv
hw/trigger_channel.sv
hw/frame_status.sv
hw/sensor_sync_top.sv
bench/tb_clock_gen.sv
bench/tb_sensor_sync.sv

// ==== bench/tb_sensor_sync.sv ====
module tb_sensor_sync
    import sync_pkg::*;
();

    localparam int NUM_CH = 2;
    localparam int CNT_W  = 24;
    localparam int NROWS  = 4;

    logic                   clk;
    logic                   rst_n;
    logic                   i_cfg_valid;
    cfg_op_t                i_cfg_op;
    logic [CH_SEL_W-1:0]    i_cfg_ch;
    logic [CNT_W-1:0]       i_cfg_data;
    logic                   o_cfg_ready;
    logic                   o_rec_valid;
    logic                   i_rec_ready;
    logic [FRAME_CNT_W-1:0] o_rec_frame;
    logic [NUM_CH-1:0]      o_rec_overrun;
    logic                   o_rec_lost;
    logic                   o_radar_fs;
    logic [NUM_CH-1:0]      o_trig;

    tb_clock_gen #(.PERIOD(8)) u_clk (.o_clk(clk));

    sensor_sync_top #(.NUM_CH(NUM_CH), .CNT_W(CNT_W)) UUT (
        .clk(clk), .rst_n(rst_n),
        .i_cfg_valid(i_cfg_valid), .i_cfg_op(i_cfg_op), .i_cfg_ch(i_cfg_ch),
        .i_cfg_data(i_cfg_data), .o_cfg_ready(o_cfg_ready),
        .o_rec_valid(o_rec_valid), .i_rec_ready(i_rec_ready),
        .o_rec_frame(o_rec_frame), .o_rec_overrun(o_rec_overrun), .o_rec_lost(o_rec_lost),
        .o_radar_fs(o_radar_fs), .o_trig(o_trig)
    );

    //////////////////////////////////////////////////
    // test table

    // timing per row, then random and special flags, then expected counts
    int t_per[NROWS];
    int t_fsw[NROWS];
    int t_off[NROWS][NUM_CH];
    int t_spc[NROWS][NUM_CH];
    int t_wid[NROWS][NUM_CH];
    int t_rnd[NROWS];
    int t_lost[NROWS];
    int t_new_off[NROWS];
    int t_min_recs[NROWS];
    int t_exp_ovr[NROWS];
    int t_exp_lost[NROWS];

    int          errors;
    int          checks;
    int          cyc;
    int          limit;
    int          recs_seen;
    int          lost_seen;
    logic [31:0] ovr_seen;
    logic [31:0] lfsr;

    // reference model state
    logic                   m_run;
    int                     m_rs;
    int                     m_stop;
    int                     m_per;
    int                     m_fsw;
    int                     m_off[NUM_CH];
    int                     m_spc[NUM_CH];
    int                     m_wid[NUM_CH];
    logic                   m_act[NUM_CH];
    int                     m_seq[NUM_CH];
    logic [NUM_CH-1:0]      m_pend;
    logic [NUM_CH-1:0]      m_ovr_acc;
    logic                   m_valid;
    logic                   m_lost;
    logic                   m_lost_pend;
    logic [FRAME_CNT_W-1:0] m_frame_cnt;
    logic [FRAME_CNT_W-1:0] m_rec_frame;
    logic [NUM_CH-1:0]      m_rec_ovr;

    task automatic add_row(input int r, input int per, input int fsw,
                           input int off0, input int spc0, input int wid0,
                           input int off1, input int spc1, input int wid1,
                           input int rnd, input int lost, input int new_off,
                           input int min_recs, input int exp_ovr, input int exp_lost);
        t_per[r]      = per;
        t_fsw[r]      = fsw;
        t_off[r][0]   = off0;
        t_spc[r][0]   = spc0;
        t_wid[r][0]   = wid0;
        t_off[r][1]   = off1;
        t_spc[r][1]   = spc1;
        t_wid[r][1]   = wid1;
        t_rnd[r]      = rnd;
        t_lost[r]     = lost;
        t_new_off[r]  = new_off;
        t_min_recs[r] = min_recs;
        t_exp_ovr[r]  = exp_ovr;
        t_exp_lost[r] = exp_lost;
    endtask

    //////////////////////////////////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    // called on a falling edge, returns on the falling edge after the accept
    task automatic cfg_write(input cfg_op_t op, input int ch, input int data,
                             output int waited);
        waited      = 0;
        i_cfg_valid = 1'b1;
        i_cfg_op    = op;
        i_cfg_ch    = CH_SEL_W'(ch);
        i_cfg_data  = CNT_W'(data);
        while (!o_cfg_ready) begin
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        i_cfg_valid = 1'b0;
    endtask

    task automatic wait_rise();
        logic prev;
        prev = o_radar_fs;
        @(negedge clk);
        while (!(o_radar_fs && !prev)) begin
            prev = o_radar_fs;
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////
    // one row: configure, run three frames, stop

    task automatic run_row(input int r);
        int waited;
        int held;
        int rnd;
        int e0;
        e0        = errors;
        recs_seen = 0;
        lost_seen = 0;
        ovr_seen  = '0;
        held      = 0;
        if (t_rnd[r] != 0) begin
            // offset 0..7, width 1..4, spacing stays above width
            draw_bits(3, rnd);
            t_off[r][0] = rnd;
            draw_bits(2, rnd);
            t_wid[r][0] = 1 + rnd;
        end
        cfg_write(OP_PERIOD, 0, t_per[r], waited);
        cfg_write(OP_FS_WIDTH, 0, t_fsw[r], waited);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            cfg_write(OP_OFFSET, ch, t_off[r][ch], waited);
            cfg_write(OP_SPACING, ch, t_spc[r][ch], waited);
            cfg_write(OP_WIDTH, ch, t_wid[r][ch], waited);
        end
        if (t_lost[r] != 0) begin
            i_rec_ready = 1'b0;
        end
        cfg_write(OP_RUN, 0, 0, waited);
        wait_rise();
        // issued in the tick cycle, so it has to wait for idle
        if (t_new_off[r] >= 0) begin
            cfg_write(OP_OFFSET, 0, t_new_off[r], held);
            if (held == 0) begin
                errors++;
                $display("row %0d: write during a busy frame was accepted at once", r);
            end
        end
        wait_rise();
        wait_rise();
        i_rec_ready = 1'b1;
        cfg_write(OP_STOP, 0, 0, waited);
        repeat (8) @(negedge clk);
        if (recs_seen < t_min_recs[r]) begin
            errors++;
            $display("row %0d: only %0d frame records arrived, %0d expected",
                     r, recs_seen, t_min_recs[r]);
        end
        check_value("overrun bits seen", ovr_seen, t_exp_ovr[r]);
        check_value("lost records seen", lost_seen, t_exp_lost[r]);
        $display("row %0d: period %0d ch0 offset %0d width %0d, %0d records, %0d errors",
                 r, t_per[r], t_off[r][0], t_wid[r][0], recs_seen, errors - e0);
    endtask

    //////////////////////////////////////////////////
    // cycle model and checks on the rising edge

    always @(posedge clk) begin : model_check
        int                d;
        int                k;
        int                len;
        logic              tick;
        logic              fs_e;
        logic              ready_e;
        logic              free;
        logic [NUM_CH-1:0] trig_e;
        logic [NUM_CH-1:0] busy_e;
        logic [NUM_CH-1:0] done_e;
        logic [NUM_CH-1:0] ovr_e;
        if (rst_n) begin
            // frame-start from the run start, also in the first cycle after stop
            fs_e = 1'b0;
            tick = 1'b0;
            if ((m_run || (cyc == m_stop)) && (m_per > 0)) begin
                d    = cyc - m_rs;
                fs_e = (d >= m_per) && ((d % m_per) < m_fsw);
                tick = m_run && (d >= m_per) && ((d % m_per) == 0);
            end
            // two pulses counted from the accepted tick
            for (int i = 0; i < NUM_CH; i++) begin
                k         = cyc - m_seq[i];
                len       = m_off[i] + m_spc[i] + m_wid[i] + 2;
                trig_e[i] = m_act[i] &&
                            (((k > m_off[i]) && (k <= m_off[i] + m_wid[i])) ||
                             ((k > m_off[i] + m_spc[i]) &&
                              (k <= m_off[i] + m_spc[i] + m_wid[i])));
                done_e[i] = m_act[i] && (k == len - 1);
                ovr_e[i]  = tick && m_act[i];
                busy_e[i] = m_act[i] || tick;
            end
            ready_e = !m_run || (busy_e == '0);
            check_value("o_radar_fs", o_radar_fs, fs_e);
            check_value("o_trig", o_trig, trig_e);
            check_value("o_cfg_ready", o_cfg_ready, ready_e);
            check_value("o_rec_valid", o_rec_valid, m_valid);
            if (m_valid && o_rec_valid) begin
                check_value("o_rec_frame", o_rec_frame, m_rec_frame);
                check_value("o_rec_overrun", o_rec_overrun, m_rec_ovr);
                check_value("o_rec_lost", o_rec_lost, m_lost);
            end
            if (o_rec_valid && i_rec_ready) begin
                recs_seen++;
                ovr_seen = ovr_seen | o_rec_overrun;
                if (o_rec_lost) begin
                    lost_seen++;
                end
            end
            // channel sequences for the next cycle
            for (int i = 0; i < NUM_CH; i++) begin
                len = m_off[i] + m_spc[i] + m_wid[i] + 2;
                if (m_act[i] && (cyc - m_seq[i] == len - 1)) begin
                    m_act[i] = 1'b0;
                end else if (tick && !m_act[i]) begin
                    m_act[i] = 1'b1;
                    m_seq[i] = cyc;
                end
            end
            // frame ends when every channel has reported done
            m_pend    = m_pend | done_e;
            m_ovr_acc = m_ovr_acc | ovr_e;
            free      = !m_valid || i_rec_ready;
            if (&m_pend) begin
                if (free) begin
                    m_valid     = 1'b1;
                    m_rec_frame = m_frame_cnt;
                    m_rec_ovr   = m_ovr_acc;
                    m_lost      = m_lost_pend;
                end
                m_lost_pend = !free;
                m_frame_cnt = m_frame_cnt + 1'b1;
                m_pend      = '0;
                m_ovr_acc   = '0;
            end else if (i_rec_ready) begin
                m_valid = 1'b0;
            end
            // accepted configuration write
            if (i_cfg_valid && o_cfg_ready) begin
                case (i_cfg_op)
                    OP_PERIOD:   m_per = int'(i_cfg_data);
                    OP_FS_WIDTH: m_fsw = int'(i_cfg_data);
                    OP_OFFSET:   m_off[i_cfg_ch] = int'(i_cfg_data);
                    OP_SPACING:  m_spc[i_cfg_ch] = int'(i_cfg_data);
                    OP_WIDTH:    m_wid[i_cfg_ch] = int'(i_cfg_data);
                    OP_RUN: begin
                        if (!m_run) begin
                            m_rs = cyc + 1;
                        end
                        m_run = 1'b1;
                    end
                    OP_STOP: begin
                        m_run  = 1'b0;
                        m_stop = cyc + 1;
                    end
                    default: ;
                endcase
            end
        end
        cyc++;
        if (cyc > limit) begin
            $display("timeout: the run did not end within %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        errors      = 0;
        checks      = 0;
        cyc         = 0;
        lfsr        = 32'hcc50_0820;
        m_run       = 1'b0;
        m_rs        = 0;
        m_stop      = -1;
        m_per       = 0;
        m_fsw       = 0;
        m_pend      = '0;
        m_ovr_acc   = '0;
        m_valid     = 1'b0;
        m_lost      = 1'b0;
        m_lost_pend = 1'b0;
        m_frame_cnt = '0;
        m_rec_frame = '0;
        m_rec_ovr   = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            m_off[i] = 0;
            m_spc[i] = 0;
            m_wid[i] = 0;
            m_act[i] = 1'b0;
            m_seq[i] = 0;
        end
        //      per fsw  ch0 o/s/w  ch1 o/s/w  rnd lost new  recs ovr lost
        add_row(0, 40, 3, 2, 5, 2, 0, 3, 3, 0, 0, -1, 3, 0, 0);
        add_row(1, 30, 2, 0, 6, 1, 4, 8, 4, 1, 0, -1, 3, 0, 0);
        add_row(2, 36, 4, 3, 6, 2, 1, 4, 2, 0, 1, 10, 2, 0, 1);
        // ch1 sequence longer than the period
        add_row(3, 20, 2, 1, 3, 2, 6, 8, 5, 0, 0, -1, 2, 2, 0);
        limit = 8 + 40;
        for (int r = 0; r < NROWS; r++) begin
            limit += 4 * t_per[r] + 200;
        end
        rst_n       = 1'b0;
        i_cfg_valid = 1'b0;
        i_cfg_op    = OP_PERIOD;
        i_cfg_ch    = '0;
        i_cfg_data  = '0;
        i_rec_ready = 1'b1;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        // stopped, outputs must stay quiet
        repeat (30) @(negedge clk);
        $display("%0d tests, %0d checks, %0d errors", NROWS, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic o_clk
);

    // free running, first rise at half a period
    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// ==== hw/sensor_sync_top.sv ====
module sensor_sync_top
    import sync_pkg::*;
#(
    parameter int NUM_CH = 2,
    parameter int CNT_W  = 24
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_cfg_valid,
    input  cfg_op_t                i_cfg_op,
    input  logic [CH_SEL_W-1:0]    i_cfg_ch,
    input  logic [CNT_W-1:0]       i_cfg_data,
    output logic                   o_cfg_ready,
    output logic                   o_rec_valid,
    input  logic                   i_rec_ready,
    output logic [FRAME_CNT_W-1:0] o_rec_frame,
    output logic [NUM_CH-1:0]      o_rec_overrun,
    output logic                   o_rec_lost,
    output logic                   o_radar_fs,
    output logic [NUM_CH-1:0]      o_trig
);

    logic                    run;
    logic [CNT_W-1:0]        period;
    logic [CNT_W-1:0]        fs_width;
    logic [NUM_CH*CNT_W-1:0] offset;
    logic [NUM_CH*CNT_W-1:0] spacing;
    logic [NUM_CH*CNT_W-1:0] width;
    logic                    frame_tick;
    logic [NUM_CH-1:0]       busy;
    logic [NUM_CH-1:0]       done;
    logic [NUM_CH-1:0]       overrun;

    //////////////////////////////////////////////////
    // configuration and radar timing

    sync_cfg_regs #(.NUM_CH(NUM_CH), .CNT_W(CNT_W)) u_cfg (
        .clk(clk), .rst_n(rst_n),
        .i_cfg_valid(i_cfg_valid), .i_cfg_op(i_cfg_op), .i_cfg_ch(i_cfg_ch),
        .i_cfg_data(i_cfg_data), .o_cfg_ready(o_cfg_ready), .i_busy(busy),
        .o_run(run), .o_period(period), .o_fs_width(fs_width),
        .o_offset(offset), .o_spacing(spacing), .o_width(width)
    );

    radar_frame_timer #(.CNT_W(CNT_W)) u_timer (
        .clk(clk), .rst_n(rst_n), .i_run(run), .i_period(period),
        .i_fs_width(fs_width), .o_radar_fs(o_radar_fs), .o_frame_tick(frame_tick)
    );

    //////////////////////////////////////////////////
    // sensor channels

    // one slice of each timing bus per channel
    for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
        trigger_channel #(.CNT_W(CNT_W)) u_ch (
            .clk(clk), .rst_n(rst_n), .i_run(run), .i_frame_tick(frame_tick),
            .i_offset(offset[g*CNT_W +: CNT_W]), .i_spacing(spacing[g*CNT_W +: CNT_W]),
            .i_width(width[g*CNT_W +: CNT_W]), .o_trig(o_trig[g]), .o_busy(busy[g]),
            .o_done(done[g]), .o_overrun(overrun[g])
        );
    end

    // frame records over all channels
    frame_status #(.NUM_CH(NUM_CH)) u_status (
        .clk(clk), .rst_n(rst_n), .i_done(done), .i_overrun(overrun),
        .o_rec_valid(o_rec_valid), .i_rec_ready(i_rec_ready),
        .o_rec_frame(o_rec_frame), .o_rec_overrun(o_rec_overrun), .o_rec_lost(o_rec_lost)
    );

endmodule

// ==== hw/frame_status.sv ====
module frame_status
    import sync_pkg::*;
#(
    parameter int NUM_CH = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [NUM_CH-1:0]      i_done,
    input  logic [NUM_CH-1:0]      i_overrun,
    output logic                   o_rec_valid,
    input  logic                   i_rec_ready,
    output logic [FRAME_CNT_W-1:0] o_rec_frame,
    output logic [NUM_CH-1:0]      o_rec_overrun,
    output logic                   o_rec_lost
);

    logic [NUM_CH-1:0]      done_pend;
    logic [NUM_CH-1:0]      ovr_pend;
    logic [NUM_CH-1:0]      done_all;
    logic [NUM_CH-1:0]      ovr_all;
    logic [FRAME_CNT_W-1:0] frame_num;
    logic                   lost_pend;
    logic                   frame_end;
    logic                   rec_free;
    logic                   rec_load;

    // this cycle's flags folded into the pending masks
    assign done_all  = done_pend | i_done;
    assign ovr_all   = ovr_pend | i_overrun;
    assign frame_end = &done_all;
    // slot free, or the held record leaves this cycle
    assign rec_free  = !o_rec_valid || i_rec_ready;
    assign rec_load  = frame_end && rec_free;

    //////////////////////////////////////////////////
    // frame collection

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_pend <= '0;
            ovr_pend  <= '0;
            frame_num <= '0;
            lost_pend <= 1'b0;
        end else if (frame_end) begin
            done_pend <= '0;
            ovr_pend  <= '0;
            // number advances on dropped frames too
            frame_num <= frame_num + 1'b1;
            lost_pend <= !rec_load;
        end else begin
            done_pend <= done_all;
            ovr_pend  <= ovr_all;
        end
    end

    //////////////////////////////////////////////////
    // record output

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rec_valid <= 1'b0;
        end else if (rec_load) begin
            o_rec_valid <= 1'b1;
        end else if (i_rec_ready) begin
            o_rec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rec_load) begin
            o_rec_frame   <= frame_num;
            o_rec_overrun <= ovr_all;
            o_rec_lost    <= lost_pend;
        end
    end

    // held record does not move
    a_rec_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (o_rec_valid && !i_rec_ready) |=> (o_rec_valid && $stable(o_rec_frame) &&
        $stable(o_rec_overrun) && $stable(o_rec_lost)));

endmodule

// ==== hw/trigger_channel.sv ====
module trigger_channel
    import sync_pkg::*;
#(
    parameter int CNT_W = 24
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_run,
    input  logic             i_frame_tick,
    input  logic [CNT_W-1:0] i_offset,
    input  logic [CNT_W-1:0] i_spacing,
    input  logic [CNT_W-1:0] i_width,
    output logic             o_trig,
    output logic             o_busy,
    output logic             o_done,
    output logic             o_overrun
);

    trig_state_t state;
    trig_state_t state_nxt;

    // cycle index from the tick, two extra bits for the sums
    logic [CNT_W+1:0] cnt;
    logic [CNT_W+1:0] a_start;
    logic [CNT_W+1:0] a_end;
    logic [CNT_W+1:0] b_start;
    logic [CNT_W+1:0] b_end;

    // last cycle before each edge of the pulses
    assign a_start = {2'b00, i_offset};
    assign a_end   = a_start + {2'b00, i_width};
    assign b_start = a_start + {2'b00, i_spacing};
    assign b_end   = b_start + {2'b00, i_width};

    //////////////////////////////////////////////////
    // sequence FSM

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                // offset of zero goes straight to the first pulse
                if (i_frame_tick) begin
                    state_nxt = (cnt >= a_start) ? ST_PULSE_A : ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (cnt >= a_start) begin
                    state_nxt = ST_PULSE_A;
                end
            end
            ST_PULSE_A: begin
                // no gap when spacing equals width
                if (cnt >= a_end) begin
                    state_nxt = (cnt >= b_start) ? ST_PULSE_B : ST_GAP;
                end
            end
            ST_GAP: begin
                if (cnt >= b_start) begin
                    state_nxt = ST_PULSE_B;
                end
            end
            ST_PULSE_B: begin
                if (cnt >= b_end) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
        // leaving run drops any sequence
        if (!i_run) begin
            state_nxt = ST_IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            cnt    <= '0;
            o_trig <= 1'b0;
        end else begin
            state <= state_nxt;
            // held at zero while idle, tick cycle is count 0
            if (state_nxt == ST_IDLE) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            o_trig <= (state_nxt == ST_PULSE_A) || (state_nxt == ST_PULSE_B);
        end
    end

    //////////////////////////////////////////////////
    // status

    // busy covers the tick cycle itself
    assign o_busy    = (state != ST_IDLE) || i_frame_tick;
    assign o_done    = (state == ST_DONE);
    // tick inside a sequence is skipped
    assign o_overrun = i_frame_tick && (state != ST_IDLE);

    a_trig_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_IDLE) |-> !o_trig);

endmodule

// ==== hw/radar_frame_timer.sv ====
module radar_frame_timer #(
    parameter int CNT_W = 24
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_run,
    input  logic [CNT_W-1:0] i_period,
    input  logic [CNT_W-1:0] i_fs_width,
    output logic             o_radar_fs,
    output logic             o_frame_tick
);

    logic [CNT_W-1:0] cnt_period;
    logic [CNT_W-1:0] cnt_fs;
    logic             period_end;
    logic             fs_end;
    logic             fs_d1;

    assign period_end = (cnt_period == i_period - 1'b1);
    assign fs_end     = (cnt_fs == i_fs_width - 1'b1);

    //////////////////////////////////////////////////
    // counters

    // period counter, zero in the first run cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_period <= '0;
        end else if (!i_run || period_end) begin
            cnt_period <= '0;
        end else begin
            cnt_period <= cnt_period + 1'b1;
        end
    end

    // high time of frame-start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_fs <= '0;
        end else if (!o_radar_fs || fs_end) begin
            cnt_fs <= '0;
        end else begin
            cnt_fs <= cnt_fs + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // frame-start and tick

    // end of high time wins over a new rise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_radar_fs <= 1'b0;
            fs_d1      <= 1'b0;
        end else begin
            fs_d1 <= o_radar_fs;
            if (!i_run || (o_radar_fs && fs_end)) begin
                o_radar_fs <= 1'b0;
            end else if (period_end) begin
                o_radar_fs <= 1'b1;
            end
        end
    end

    // rising edge, dropped if stop lands on the rise
    assign o_frame_tick = o_radar_fs && !fs_d1 && i_run;

    // frame-start only rises out of a running cycle
    a_tick_run: assert property (@(posedge clk) disable iff (!rst_n)
        o_frame_tick |-> $past(i_run));

endmodule

// ==== hw/sync_cfg_regs.sv ====
module sync_cfg_regs
    import sync_pkg::*;
#(
    parameter int NUM_CH = 2,
    parameter int CNT_W  = 24
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_cfg_valid,
    input  cfg_op_t                 i_cfg_op,
    input  logic [CH_SEL_W-1:0]     i_cfg_ch,
    input  logic [CNT_W-1:0]        i_cfg_data,
    output logic                    o_cfg_ready,
    input  logic [NUM_CH-1:0]       i_busy,
    output logic                    o_run,
    output logic [CNT_W-1:0]        o_period,
    output logic [CNT_W-1:0]        o_fs_width,
    output logic [NUM_CH*CNT_W-1:0] o_offset,
    output logic [NUM_CH*CNT_W-1:0] o_spacing,
    output logic [NUM_CH*CNT_W-1:0] o_width
);

    logic cfg_wr;
    logic ch_op;

    // writes only between trigger sequences
    assign o_cfg_ready = !o_run || (i_busy == '0);
    assign cfg_wr      = i_cfg_valid && o_cfg_ready;
    assign ch_op       = (i_cfg_op == OP_OFFSET) || (i_cfg_op == OP_SPACING) ||
                         (i_cfg_op == OP_WIDTH);

    //////////////////////////////////////////////////
    // run state

    // run rises the cycle after OP_RUN is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_run <= 1'b0;
        end else if (cfg_wr && (i_cfg_op == OP_RUN)) begin
            o_run <= 1'b1;
        end else if (cfg_wr && (i_cfg_op == OP_STOP)) begin
            o_run <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // timing registers

    // radar frame timing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_period   <= '0;
            o_fs_width <= '0;
        end else if (cfg_wr) begin
            if (i_cfg_op == OP_PERIOD) begin
                o_period <= i_cfg_data;
            end
            if (i_cfg_op == OP_FS_WIDTH) begin
                o_fs_width <= i_cfg_data;
            end
        end
    end

    // per channel slices of the flat buses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_offset  <= '0;
            o_spacing <= '0;
            o_width   <= '0;
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (cfg_wr && ch_op && (i_cfg_ch == CH_SEL_W'(i))) begin
                    case (i_cfg_op)
                        OP_OFFSET:  o_offset[i*CNT_W +: CNT_W]  <= i_cfg_data;
                        OP_SPACING: o_spacing[i*CNT_W +: CNT_W] <= i_cfg_data;
                        OP_WIDTH:   o_width[i*CNT_W +: CNT_W]   <= i_cfg_data;
                        default:    ;
                    endcase
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // checks

    // host never addresses a channel that is not built
    a_ch_range: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg_wr && ch_op) |-> (i_cfg_ch < NUM_CH));

    // second pulse must not start inside the first one
    for (genvar g = 0; g < NUM_CH; g++) begin : g_chk
        a_spacing: assert property (@(posedge clk) disable iff (!rst_n)
            o_run |-> (o_spacing[g*CNT_W +: CNT_W] >= o_width[g*CNT_W +: CNT_W]));
    end

endmodule

// ==== hw/sync_pkg.sv ====
package sync_pkg;

    //////////////////////////////////////////////////
    // configuration port

    // opcodes carried on i_cfg_op
    typedef enum logic [2:0] {
        // radar frame period in cycles
        OP_PERIOD   = 3'd0,
        // radar frame-start high time
        OP_FS_WIDTH = 3'd1,
        // per channel, picked by i_cfg_ch
        OP_OFFSET   = 3'd2,
        OP_SPACING  = 3'd3,
        OP_WIDTH    = 3'd4,
        // run control
        OP_RUN      = 3'd5,
        OP_STOP     = 3'd6
    } cfg_op_t;

    // channel select field, up to 16 channels
    localparam int CH_SEL_W = 4;

    //////////////////////////////////////////////////
    // trigger channel

    // two-pulse sequence per radar frame
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_WAIT    = 3'd1,
        ST_PULSE_A = 3'd2,
        ST_GAP     = 3'd3,
        ST_PULSE_B = 3'd4,
        ST_DONE    = 3'd5
    } trig_state_t;

    //////////////////////////////////////////////////
    // frame record

    // frame number width, wraps
    localparam int FRAME_CNT_W = 16;

endpackage
